/* verilog.f */
logic/pmp_pkg.sv
logic/pmp_cfg_if.sv
logic/pmp_cfg_regs.sv
logic/pmp_addr_regs.sv
logic/pmp_csr_read.sv
logic/pmp_regs.sv
tb/tb_clk_gen.sv
tb/tb_pmp_regs.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PMP register file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_pmp_regs -f verilog.f

sim_out=$(./obj_dir/Vtb_pmp_regs || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TB PASSED"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb/tb_pmp_regs.sv */
//--------------------------------------------------
// Directed testbench for the PMP register file
//   Reference model of pmpcfg0 and pmpaddr0-7
//   Compare tasks for CSR words and stored addresses
//   Reset, write, format and lock tests
//--------------------------------------------------
`timescale 1ns/1ps

module tb_pmp_regs;
  import pmp_pkg::*;

  localparam int reset_timeout = 50;
  localparam csr_data_t no_lock_mask = 64'h7f7f_7f7f_7f7f_7f7f;
  localparam csr_data_t field_mask   = 64'h1f1f_1f1f_1f1f_1f1f;

  logic          cpuclk;
  logic          cpurst_b;
  csr_data_t     cp0_pmp_wdata;
  csr_onehot_t   pmp_csr_sel;
  csr_onehot_t   pmp_csr_wen;
  csr_data_t     pmp_cp0_data;
  csr_data_t     pmpcfg0_value;
  pmp_addr_arr_t pmpaddr_value;

  integer        seed;
  // Expected register contents
  csr_data_t     cfg_model;
  pmp_addr_arr_t addr_model;

  tb_clk_gen i_clk_gen (
    .cpuclk   (cpuclk),
    .cpurst_b (cpurst_b)
  );

  pmp_regs i_dut (
    .cpuclk        (cpuclk),
    .cpurst_b      (cpurst_b),
    .cp0_pmp_wdata (cp0_pmp_wdata),
    .pmp_csr_sel   (pmp_csr_sel),
    .pmp_csr_wen   (pmp_csr_wen),
    .pmp_cp0_data  (pmp_cp0_data),
    .pmpcfg0_value (pmpcfg0_value),
    .pmpaddr_value (pmpaddr_value)
  );

  //--------------------------------------------------
  // Error handling and compare tasks
  //--------------------------------------------------
  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
    if (act !== exp)
    begin
      $display("FAIL at %0t: %s expected 0x%h actual 0x%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input pmp_addr_t exp, input pmp_addr_t act);
    if (act !== exp)
    begin
      $display("FAIL at %0t: %s expected 0x%h actual 0x%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  //--------------------------------------------------
  // Reference model
  //--------------------------------------------------
  function automatic logic slot_locked(input csr_data_t cfg, input int i);
    return cfg[i*cfg_slot_w + cfg_bit_l];
  endfunction

  function automatic logic [1:0] slot_mode(input csr_data_t cfg, input int i);
    return cfg[i*cfg_slot_w + cfg_mode_lo +: 2];
  endfunction

  // Unlocked slots take the new byte minus bits 5 and 6
  function automatic csr_data_t cfg_after_write(input csr_data_t old_cfg, input csr_data_t d);
    csr_data_t res;
    res = old_cfg;
    for (int i = 0; i < pmp_entries; i++)
    begin
      if (!slot_locked(old_cfg, i))
      begin
        res[i*cfg_slot_w +: cfg_slot_w] = d[i*cfg_slot_w +: cfg_slot_w] & 8'h9f;
      end
    end
    return res;
  endfunction

  function automatic logic addr_blocked(input csr_data_t cfg, input int i);
    logic blocked;
    blocked = slot_locked(cfg, i);
    if (i < pmp_entries - 1)
    begin
      if (slot_locked(cfg, i + 1) && (slot_mode(cfg, i + 1) == mode_tor))
      begin
        blocked = 1'b1;
      end
    end
    return blocked;
  endfunction

  // NA4 and NAPOT fill the grain bits below stored bit 0 with ones
  function automatic csr_data_t addr_read_word(input pmp_addr_t stored, input logic [1:0] mode);
    csr_data_t word;
    word = csr_data_t'(stored) << pmp_addr_lsb;
    if (mode[1])
    begin
      word[pmp_addr_lsb-1:0] = '1;
    end
    else
    begin
      word[pmp_grain_w-1:0] = '0;
    end
    return word;
  endfunction

  //--------------------------------------------------
  // Drive tasks
  //--------------------------------------------------
  task automatic get_random(output csr_data_t d);
    d = {$random(seed), $random(seed)};
  endtask

  // Write lands on the second edge, checked at the following falling edge
  task automatic write_csr(input int idx, input csr_data_t d);
    @(posedge cpuclk);
    cp0_pmp_wdata <= d;
    pmp_csr_wen   <= csr_onehot_t'(1) << idx;
    @(posedge cpuclk);
    pmp_csr_wen   <= '0;
    @(negedge cpuclk);
  endtask

  task automatic read_csr(input int idx, input csr_data_t exp, input string name);
    @(posedge cpuclk);
    pmp_csr_sel <= csr_onehot_t'(1) << idx;
    @(negedge cpuclk);
    check_data(name, exp, pmp_cp0_data);
  endtask

  task automatic check_all_addr();
    for (int i = 0; i < pmp_entries; i++)
    begin
      check_addr($sformatf("pmpaddr_value[%0d]", i), addr_model[i], pmpaddr_value[i]);
    end
  endtask

  task automatic write_cfg(input csr_data_t d);
    cfg_model = cfg_after_write(cfg_model, d);
    write_csr(csr_idx_cfg0, d);
    check_data("pmpcfg0_value", cfg_model, pmpcfg0_value);
  endtask

  task automatic write_addr(input int i, input csr_data_t d);
    if (!addr_blocked(cfg_model, i))
    begin
      addr_model[i] = d[pmp_addr_lsb +: pmp_addr_w];
    end
    write_csr(csr_idx_addr0 + i, d);
    check_all_addr();
  endtask

  task automatic read_all_csr();
    read_csr(csr_idx_cfg0, cfg_model, "pmp_cp0_data pmpcfg0");
    for (int i = 0; i < pmp_entries; i++)
    begin
      read_csr(csr_idx_addr0 + i, addr_read_word(addr_model[i], slot_mode(cfg_model, i)),
               $sformatf("pmp_cp0_data pmpaddr%0d", i));
    end
  endtask

  //--------------------------------------------------
  // Tests
  //--------------------------------------------------
  task automatic test_reset_state();
    int cycles;
    cycles = 0;
    while (cpurst_b !== 1'b1 && cycles < reset_timeout)
    begin
      @(negedge cpuclk);
      cycles++;
    end
    if (cpurst_b !== 1'b1)
    begin
      $display("Reset was not released within %0d cycles", reset_timeout);
      abort_run();
    end
    check_data("pmpcfg0_value", '0, pmpcfg0_value);
    check_all_addr();
    read_all_csr();
  endtask

  task automatic test_cfg_write();
    csr_data_t d;
    get_random(d);
    d = d & no_lock_mask;
    write_cfg(d);
    check_data("pmpcfg0_value", d & field_mask, pmpcfg0_value);
    read_csr(csr_idx_cfg0, d & field_mask, "pmp_cp0_data pmpcfg0");
  endtask

  task automatic test_addr_write();
    csr_data_t d;
    for (int i = 0; i < pmp_entries; i++)
    begin
      get_random(d);
      write_addr(i, d);
      check_addr($sformatf("pmpaddr_value[%0d]", i), d[37:9], pmpaddr_value[i]);
    end
    // Modes off, tor, na4, napot repeated across the slots
    get_random(d);
    d = d & no_lock_mask;
    for (int i = 0; i < pmp_entries; i++)
    begin
      d[i*cfg_slot_w + cfg_mode_lo +: 2] = 2'(i % 4);
    end
    write_cfg(d);
    read_all_csr();
  endtask

  task automatic test_cfg_lock();
    csr_data_t first;
    csr_data_t second;
    logic [7:0] slot5_byte;
    get_random(first);
    first = first & no_lock_mask;
    first[5*cfg_slot_w + cfg_bit_l] = 1'b1;
    // Entry 3 locked TOR, entry 1 locked NAPOT for the address lock test
    first[3*cfg_slot_w + cfg_mode_lo +: 2] = mode_tor;
    first[3*cfg_slot_w + cfg_bit_l] = 1'b1;
    first[1*cfg_slot_w + cfg_mode_lo +: 2] = mode_napot;
    first[1*cfg_slot_w + cfg_bit_l] = 1'b1;
    write_cfg(first);
    slot5_byte = first[47:40] & 8'h9f;
    get_random(second);
    second = second & no_lock_mask;
    write_cfg(second);
    check_data("pmpcfg0_value slot 5", csr_data_t'(slot5_byte),
               csr_data_t'(pmpcfg0_value[47:40]));
    check_data("pmpcfg0_value slot 0", csr_data_t'(second[7:0] & 8'h1f),
               csr_data_t'(pmpcfg0_value[7:0]));
    read_csr(csr_idx_cfg0, cfg_model, "pmp_cp0_data pmpcfg0");
  endtask

  task automatic test_addr_lock();
    pmp_addr_arr_t saved;
    csr_data_t d;
    csr_data_t d0;
    saved = addr_model;
    d0 = '0;
    for (int i = 0; i < pmp_entries; i++)
    begin
      get_random(d);
      if (i == 0)
      begin
        d0 = d;
      end
      write_addr(i, d);
    end
    check_addr("pmpaddr_value[5]", saved[5], pmpaddr_value[5]);
    check_addr("pmpaddr_value[2]", saved[2], pmpaddr_value[2]);
    check_addr("pmpaddr_value[0]", d0[37:9], pmpaddr_value[0]);
    read_all_csr();
    // Registers now hold nonzero data, so an empty select must still read zero
    @(posedge cpuclk);
    pmp_csr_sel <= '0;
    @(negedge cpuclk);
    check_data("pmp_cp0_data no select", '0, pmp_cp0_data);
  endtask

  initial
  begin
    seed          = 86;
    cp0_pmp_wdata = '0;
    pmp_csr_sel   = '0;
    pmp_csr_wen   = '0;
    cfg_model     = '0;
    addr_model    = '0;
    test_reset_state();
    test_cfg_write();
    test_addr_write();
    test_cfg_lock();
    test_addr_lock();
    $display("TB PASSED");
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
//--------------------------------------------------
// Testbench clock and reset generator
//   4 ns cpuclk
//   Active low reset held for 5 cycles
//--------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
  output logic cpuclk,
  output logic cpurst_b
);

  localparam int rst_cycles = 5;

  initial
  begin
    cpuclk = 1'b0;
    forever #2 cpuclk = ~cpuclk;
  end

  initial
  begin
    cpurst_b = 1'b0;
    repeat (rst_cycles) @(posedge cpuclk);
    cpurst_b <= 1'b1;
  end

endmodule

/* logic/pmp_regs.sv */
//--------------------------------------------------
// PMP register file top level
//   pmpcfg0 and pmpaddr0 to pmpaddr7
//   One-hot CSR write enables and select
//   Combinational read bus
//--------------------------------------------------
`timescale 1ns/1ps

module pmp_regs (
  input  logic                   cpuclk,
  input  logic                   cpurst_b,
  input  pmp_pkg::csr_data_t     cp0_pmp_wdata,
  input  pmp_pkg::csr_onehot_t   pmp_csr_sel,
  input  pmp_pkg::csr_onehot_t   pmp_csr_wen,
  output pmp_pkg::csr_data_t     pmp_cp0_data,
  output pmp_pkg::csr_data_t     pmpcfg0_value,
  output pmp_pkg::pmp_addr_arr_t pmpaddr_value
);
  import pmp_pkg::*;

  logic       cfg_wen;
  entry_vec_t addr_wen;

  // Split one-hot write enables per register group
  assign cfg_wen  = pmp_csr_wen[csr_idx_cfg0];
  assign addr_wen = pmp_csr_wen[csr_idx_addr0 +: pmp_entries];

  pmp_cfg_if i_cfg_if ();

  pmp_cfg_regs i_cfg_regs (
    .cpuclk   (cpuclk),
    .cpurst_b (cpurst_b),
    .cfg_wen  (cfg_wen),
    .wdata    (cp0_pmp_wdata),
    .cfg_word (pmpcfg0_value),
    .cfg      (i_cfg_if.owner)
  );

  pmp_addr_regs i_addr_regs (
    .cpuclk     (cpuclk),
    .cpurst_b   (cpurst_b),
    .addr_wen   (addr_wen),
    .wdata      (cp0_pmp_wdata),
    .addr_value (pmpaddr_value),
    .cfg        (i_cfg_if.addr_ctl)
  );

  pmp_csr_read i_csr_read (
    .csr_sel    (pmp_csr_sel),
    .cfg_word   (pmpcfg0_value),
    .addr_value (pmpaddr_value),
    .rdata      (pmp_cp0_data),
    .cfg        (i_cfg_if.reader)
  );

endmodule

/* logic/pmp_csr_read.sv */
//--------------------------------------------------
// PMP CSR read path
//   Address read-back with NA4/NAPOT low-bit fill
//   One-hot AND-OR read multiplexer
//--------------------------------------------------
`timescale 1ns/1ps

module pmp_csr_read (
  input  pmp_pkg::csr_onehot_t   csr_sel,
  input  pmp_pkg::csr_data_t     cfg_word,
  input  pmp_pkg::pmp_addr_arr_t addr_value,
  output pmp_pkg::csr_data_t     rdata,
  pmp_cfg_if.reader              cfg
);
  import pmp_pkg::*;

  csr_data_t [pmp_entries-1:0] addr_word;

  //--------------------------------------------------
  // Address read-back formatting
  //--------------------------------------------------
  for (genvar i = 0; i < pmp_entries; i++)
  begin : g_fmt
    logic [pmp_grain_w-1:0] addr_low;

    // NA4 and NAPOT show stored bit 0 then all ones
    assign addr_low = (cfg.entry_mode[i] inside {mode_na4, mode_napot}) ?
                      {addr_value[i][0], {(pmp_grain_w-1){1'b1}}} : '0;

    assign addr_word[i] = {{(csr_data_w-pmp_addr_w-pmp_grain_w+1){1'b0}},
                           addr_value[i][pmp_addr_w-1:1],
                           addr_low};
  end

  //--------------------------------------------------
  // Read mux
  //--------------------------------------------------
  always_comb
  begin
    rdata = {csr_data_w{csr_sel[csr_idx_cfg0]}} & cfg_word;
    for (int i = 0; i < pmp_entries; i++)
    begin
      rdata = rdata | ({csr_data_w{csr_sel[csr_idx_addr0+i]}} & addr_word[i]);
    end
  end

endmodule

/* logic/pmp_addr_regs.sv */
//--------------------------------------------------
// PMP address registers pmpaddr0 to pmpaddr7
//   Stores write data bits 37 to 9
//   Write blocked by own lock or by a locked
//   TOR entry directly above
//--------------------------------------------------
`timescale 1ns/1ps

module pmp_addr_regs (
  input  logic                   cpuclk,
  input  logic                   cpurst_b,
  input  pmp_pkg::entry_vec_t    addr_wen,
  input  pmp_pkg::csr_data_t     wdata,
  output pmp_pkg::pmp_addr_arr_t addr_value,
  pmp_cfg_if.addr_ctl            cfg
);
  import pmp_pkg::*;

  entry_vec_t tor_lock;
  entry_vec_t next_tor_lock;
  entry_vec_t addr_upd;

  //--------------------------------------------------
  // Write lock rules
  //--------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < pmp_entries; i++)
    begin
      tor_lock[i] = cfg.entry_lock[i] && (cfg.entry_mode[i] == mode_tor);
    end
  end

  // Entry i sees the TOR lock of entry i+1, the last entry has none above
  assign next_tor_lock = {1'b0, tor_lock[pmp_entries-1:1]};

  assign addr_upd = addr_wen & ~cfg.entry_lock & ~next_tor_lock;

  //--------------------------------------------------
  // Address storage
  //--------------------------------------------------
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      addr_value <= '0;
    end
    else
    begin
      for (int i = 0; i < pmp_entries; i++)
      begin
        if (addr_upd[i])
        begin
          addr_value[i] <= wdata[pmp_addr_lsb +: pmp_addr_w];
        end
      end
    end
  end

endmodule

/* logic/pmp_cfg_regs.sv */
//--------------------------------------------------
// PMP configuration slots for eight entries
//   Per-slot R/W/X, address mode and lock fields
//   Locked slots ignore pmpcfg0 writes
//   Packed pmpcfg0 view with bits 5 and 6 as zero
//--------------------------------------------------
`timescale 1ns/1ps

module pmp_cfg_regs (
  input  logic                cpuclk,
  input  logic                cpurst_b,
  input  logic                cfg_wen,
  input  pmp_pkg::csr_data_t  wdata,
  output pmp_pkg::csr_data_t  cfg_word,
  pmp_cfg_if.owner            cfg
);
  import pmp_pkg::*;

  entry_vec_t      slot_r;
  entry_vec_t      slot_w;
  entry_vec_t      slot_x;
  entry_vec_t      slot_l;
  entry_mode_arr_t slot_mode;

  //--------------------------------------------------
  // Slot registers
  //--------------------------------------------------
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      slot_r <= '0;
      slot_w <= '0;
      slot_x <= '0;
      slot_l <= '0;
      for (int i = 0; i < pmp_entries; i++)
      begin
        slot_mode[i] <= mode_off;
      end
    end
    else if (cfg_wen)
    begin
      for (int i = 0; i < pmp_entries; i++)
      begin
        // Lock holds the slot until reset
        if (!slot_l[i])
        begin
          slot_r[i]    <= wdata[i*cfg_slot_w + cfg_bit_r];
          slot_w[i]    <= wdata[i*cfg_slot_w + cfg_bit_w];
          slot_x[i]    <= wdata[i*cfg_slot_w + cfg_bit_x];
          slot_mode[i] <= pmp_mode_e'(wdata[i*cfg_slot_w + cfg_mode_lo +: $bits(pmp_mode_e)]);
          slot_l[i]    <= wdata[i*cfg_slot_w + cfg_bit_l];
        end
      end
    end
  end

  assign cfg.entry_r    = slot_r;
  assign cfg.entry_w    = slot_w;
  assign cfg.entry_x    = slot_x;
  assign cfg.entry_lock = slot_l;
  assign cfg.entry_mode = slot_mode;

  //--------------------------------------------------
  // Packed pmpcfg0 word
  //--------------------------------------------------
  always_comb
  begin
    // Unused bits of each byte stay zero
    cfg_word = '0;
    for (int i = 0; i < pmp_entries; i++)
    begin
      cfg_word[i*cfg_slot_w + cfg_bit_r] = cfg.entry_r[i];
      cfg_word[i*cfg_slot_w + cfg_bit_w] = cfg.entry_w[i];
      cfg_word[i*cfg_slot_w + cfg_bit_x] = cfg.entry_x[i];
      cfg_word[i*cfg_slot_w + cfg_mode_lo +: $bits(pmp_mode_e)] = cfg.entry_mode[i];
      cfg_word[i*cfg_slot_w + cfg_bit_l] = cfg.entry_lock[i];
    end
  end

endmodule

/* logic/pmp_cfg_if.sv */
//--------------------------------------------------
// Decoded PMP configuration fields
//   owner    driven by the configuration registers
//   addr_ctl lock and mode for address write control
//   reader   mode for address read-back formatting
//--------------------------------------------------
`timescale 1ns/1ps

interface pmp_cfg_if;
  import pmp_pkg::*;

  entry_vec_t      entry_r;
  entry_vec_t      entry_w;
  entry_vec_t      entry_x;
  entry_vec_t      entry_lock;
  entry_mode_arr_t entry_mode;

  modport owner (output entry_r, entry_w, entry_x, entry_lock, entry_mode);

  modport addr_ctl (input entry_lock, entry_mode);

  modport reader (input entry_mode);

endinterface

/* logic/pmp_pkg.sv */
//--------------------------------------------------
// PMP register file shared definitions
//   Entry count and register widths
//   CSR select indices
//   Address mode encoding and per-slot bit positions
//   Register and vector types
//--------------------------------------------------
package pmp_pkg;

  localparam int pmp_entries   = 8;
  localparam int pmp_addr_w    = 29;
  localparam int csr_data_w    = 64;
  localparam int pmp_addr_lsb  = 9;
  localparam int pmp_grain_w   = 10;
  localparam int cfg_slot_w    = 8;

  // One-hot CSR select layout
  localparam int csr_num       = 9;
  localparam int csr_idx_cfg0  = 0;
  localparam int csr_idx_addr0 = 1;

  // Field positions inside one pmpcfg0 byte
  localparam int cfg_bit_r     = 0;
  localparam int cfg_bit_w     = 1;
  localparam int cfg_bit_x     = 2;
  localparam int cfg_mode_lo   = 3;
  localparam int cfg_bit_l     = 7;

  typedef enum logic [1:0] {
    mode_off   = 2'd0,
    mode_tor   = 2'd1,
    mode_na4   = 2'd2,
    mode_napot = 2'd3
  } pmp_mode_e;

  typedef logic [csr_data_w-1:0]  csr_data_t;
  typedef logic [pmp_addr_w-1:0]  pmp_addr_t;
  typedef pmp_addr_t [pmp_entries-1:0] pmp_addr_arr_t;
  typedef logic [csr_num-1:0]     csr_onehot_t;
  typedef logic [pmp_entries-1:0] entry_vec_t;
  typedef pmp_mode_e [pmp_entries-1:0] entry_mode_arr_t;

endpackage
